// File: rtl/csr_settings.svh
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// register numbers
`define CSR_CRMD    14'h0
`define CSR_PRMD    14'h1
`define CSR_ECFG    14'h4
`define CSR_ESTAT   14'h5
`define CSR_ERA     14'h6
`define CSR_EENTRY  14'hc
`define CSR_SAVE0   14'h30
`define CSR_SAVE1   14'h31
`define CSR_SAVE2   14'h32
`define CSR_SAVE3   14'h33
`define CSR_TID     14'h40
`define CSR_TCFG    14'h41
`define CSR_TVAL    14'h42
`define CSR_TICLR   14'h44

// timer counter width and its ESTAT bit
`define CSR_TIMER_BITS 16
`define CSR_TI_BIT     11

// exception codes
`define ECODE_INT   6'h0
`define ECODE_SYS   6'hb
`define ECODE_BRK   6'hc

`define ARB_PORTS   2

`endif

// File: rtl/csrPkg.sv
`default_nettype none

package csrPkg;

    // operation from the pipeline
    typedef enum logic [2:0] {
        opNone,
        opRd,
        opWr,
        opXchg,
        opErtn,
        opIdle,
        opSyscall,
        opBrk
    } csrOp;

    // payload of the shared software write port
    typedef struct packed {
        logic        we;
        logic [13:0] num;
        logic [31:0] wdata;
        logic [31:0] wmask;
    } csrWrite;

    // hardware state update on exception entry or ertn
    typedef struct packed {
        logic        valid;
        logic        isErtn;
        logic [5:0]  ecode;
        logic [31:0] era;
    } csrTrap;

    // live register fields seen by control
    typedef struct packed {
        logic [8:0]  crmd;
        logic [2:0]  prmd;
        logic [12:0] ecfgLie;
        logic [12:0] estatIs;
        logic [31:0] era;
        logic [31:0] eentry;
    } csrStatus;

endpackage

`default_nettype wire

// File: rtl/csrWriteArbiter.sv
`timescale 1ns/1ns
`default_nettype none
`include "csr_settings.svh"

module csrWriteArbiter (
    input  wire csrPkg::csrWrite [`ARB_PORTS-1:0] reqs,
    output csrPkg::csrWrite                       winner,
    output logic [`ARB_PORTS-1:0]                 grants
);

    // lowest index wins, so scan from the top down
    always_comb
    begin
        winner = '0;
        grants = '0;
        for (int i = `ARB_PORTS - 1; i >= 0; i--)
        begin
            if (reqs[i].we)
            begin
                winner    = reqs[i];
                grants    = '0;
                grants[i] = 1'b1;
            end
        end
    end

    // one owner per cycle, and a write goes out exactly when someone is granted
    always_comb
    begin
        assert ($onehot0(grants) && ((|grants) == winner.we));
    end

endmodule

`default_nettype wire

// File: rtl/csrFile.sv
`timescale 1ns/1ns
`default_nettype none
`include "csr_settings.svh"

module csrFile (
    input  wire logic                       clk,
    input  wire logic                       rstn,
    input  wire csrPkg::csrWrite            wr,
    input  wire csrPkg::csrTrap             trap,
    input  wire logic [13:0]                rdNum,
    input  wire logic [`CSR_TIMER_BITS-1:0] tval,
    input  wire logic [7:0]                 hwInt,
    output logic [31:0]                     rdata,
    output csrPkg::csrStatus                status,
    output logic [31:0]                     tcfg,
    output logic                            ticlr,
    output logic                            tcfgWritten
);

    logic [8:0]                 crmd;
    logic [2:0]                 prmd;
    logic [12:0]                ecfgLie;
    logic [1:0]                 swInt;
    logic [7:0]                 hwSample;
    logic                       timerInt;
    logic [5:0]                 ecode;
    logic [31:0]                era;
    logic [31:6]                eentry;
    logic [31:0]                save0;
    logic [31:0]                save1;
    logic [31:0]                save2;
    logic [31:0]                save3;
    logic [31:0]                tid;
    logic [`CSR_TIMER_BITS-1:0] tcfgReg;
    logic [12:0]                estatIs;
    logic [31:0]                wset;
    logic [31:0]                wkeep;

    assign wset  = wr.wdata & wr.wmask;
    assign wkeep = ~wr.wmask;

    // bit 12 (IPI) and bit 10 are not implemented
    assign estatIs = {1'b0, timerInt, 1'b0, hwSample, swInt};
    assign tcfg    = {{(32 - `CSR_TIMER_BITS){1'b0}}, tcfgReg};
    assign ticlr   = wr.we && wr.num == `CSR_TICLR && wset[0];

    assign status = '{crmd: crmd, prmd: prmd, ecfgLie: ecfgLie, estatIs: estatIs,
                      era: era, eentry: {eentry, 6'b0}};

    always_comb
    begin
        case (rdNum)
            `CSR_CRMD:   rdata = {23'b0, crmd};
            `CSR_PRMD:   rdata = {29'b0, prmd};
            `CSR_ECFG:   rdata = {19'b0, ecfgLie};
            `CSR_ESTAT:  rdata = {10'b0, ecode, 3'b0, estatIs};
            `CSR_ERA:    rdata = era;
            `CSR_EENTRY: rdata = {eentry, 6'b0};
            `CSR_SAVE0:  rdata = save0;
            `CSR_SAVE1:  rdata = save1;
            `CSR_SAVE2:  rdata = save2;
            `CSR_SAVE3:  rdata = save3;
            `CSR_TID:    rdata = tid;
            `CSR_TCFG:   rdata = tcfg;
            `CSR_TVAL:   rdata = {{(32 - `CSR_TIMER_BITS){1'b0}}, tval};
            default:     rdata = 32'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd        <= 9'h8;
            prmd        <= '0;
            ecfgLie     <= '0;
            swInt       <= '0;
            hwSample    <= '0;
            timerInt    <= 1'b0;
            ecode       <= '0;
            era         <= '0;
            eentry      <= '0;
            save0       <= '0;
            save1       <= '0;
            save2       <= '0;
            save3       <= '0;
            tid         <= '0;
            tcfgReg     <= '0;
            tcfgWritten <= 1'b0;
        end
        else
        begin
            hwSample    <= hwInt;
            tcfgWritten <= wr.we && wr.num == `CSR_TCFG;
            if (ticlr)
                timerInt <= 1'b0;
            if (wr.we)
            begin
                case (wr.num)
                    `CSR_CRMD:   crmd    <= (crmd & wkeep[8:0]) | wset[8:0];
                    `CSR_PRMD:   prmd    <= (prmd & wkeep[2:0]) | wset[2:0];
                    `CSR_ECFG:   ecfgLie <= ((ecfgLie & wkeep[12:0]) | wset[12:0]) & 13'h1bff;
                    `CSR_ESTAT:
                    begin
                        swInt <= (swInt & wkeep[1:0]) | wset[1:0];
                        // set-only path, only the timer drives this bit
                        if (wset[`CSR_TI_BIT])
                            timerInt <= 1'b1;
                    end
                    `CSR_ERA:    era     <= (era & wkeep) | wset;
                    `CSR_EENTRY: eentry  <= (eentry & wkeep[31:6]) | wset[31:6];
                    `CSR_SAVE0:  save0   <= (save0 & wkeep) | wset;
                    `CSR_SAVE1:  save1   <= (save1 & wkeep) | wset;
                    `CSR_SAVE2:  save2   <= (save2 & wkeep) | wset;
                    `CSR_SAVE3:  save3   <= (save3 & wkeep) | wset;
                    `CSR_TID:    tid     <= (tid & wkeep) | wset;
                    `CSR_TCFG:
                        tcfgReg <= (tcfgReg & wkeep[`CSR_TIMER_BITS-1:0])
                                   | wset[`CSR_TIMER_BITS-1:0];
                    default:     ;
                endcase
            end
            if (trap.valid)
            begin
                if (trap.isErtn)
                    crmd[2:0] <= prmd;
                else
                begin
                    // save PLV and IE, then drop to PLV0 with interrupts off
                    prmd      <= crmd[2:0];
                    crmd[2:0] <= 3'b0;
                    era       <= trap.era;
                    ecode     <= trap.ecode;
                end
            end
        end
    end

    // control never writes in a trap cycle, only the timer set can coincide
    assert property (@(posedge clk) disable iff (!rstn)
        trap.valid && wr.we |-> wr.num == `CSR_ESTAT && wr.wmask == (32'b1 << `CSR_TI_BIT));

endmodule

`default_nettype wire

// File: rtl/csrControl.sv
`timescale 1ns/1ns
`default_nettype none
`include "csr_settings.svh"

module csrControl (
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire logic             valid,
    input  wire csrPkg::csrOp     op,
    input  wire logic [13:0]      csrNum,
    input  wire logic [31:0]      wdata,
    input  wire logic [31:0]      wmask,
    input  wire logic [31:0]      pc,
    input  wire logic             stall,
    input  wire logic             flushIn,
    input  wire csrPkg::csrStatus status,
    output csrPkg::csrWrite       wr,
    output csrPkg::csrTrap        trap,
    output logic                  flush,
    output logic [31:0]           outPc,
    output logic                  clkStall
);

    logic accept;
    logic intPending;
    logic takeInt;

    assign accept     = valid && !stall && !flushIn && !clkStall;
    // enabled pending lines, used for both interrupt take and idle wake
    assign intPending = |(status.estatIs & status.ecfgLie);
    assign takeInt    = accept && status.crmd[2] && intPending;

    always_comb
    begin
        wr    = '0;
        trap  = '0;
        outPc = status.eentry;
        if (takeInt)
        begin
            trap.valid = 1'b1;
            trap.ecode = `ECODE_INT;
            trap.era   = pc;
        end
        else if (accept)
        begin
            case (op)
                csrPkg::opWr,
                csrPkg::opXchg:
                begin
                    wr.we    = 1'b1;
                    wr.num   = csrNum;
                    wr.wdata = wdata;
                    wr.wmask = (op == csrPkg::opXchg) ? wmask : 32'hffff_ffff;
                    // timer interrupt bit belongs to the timer
                    if (csrNum == `CSR_ESTAT)
                        wr.wmask[`CSR_TI_BIT] = 1'b0;
                end
                csrPkg::opSyscall:
                begin
                    trap.valid = 1'b1;
                    trap.ecode = `ECODE_SYS;
                    trap.era   = pc;
                end
                csrPkg::opBrk:
                begin
                    trap.valid = 1'b1;
                    trap.ecode = `ECODE_BRK;
                    trap.era   = pc;
                end
                csrPkg::opErtn:
                begin
                    trap.valid  = 1'b1;
                    trap.isErtn = 1'b1;
                    outPc       = status.era;
                end
                default: ;
            endcase
        end
        flush = trap.valid;
    end

    // core clock gate for idle
    always_ff @(posedge clk)
    begin
        if (!rstn)
            clkStall <= 1'b0;
        else if (clkStall)
        begin
            if (intPending)
                clkStall <= 1'b0;
        end
        else if (accept && !takeInt && op == csrPkg::opIdle)
            clkStall <= 1'b1;
    end

    assert property (@(posedge clk) disable iff (!rstn) clkStall |-> !flush);

endmodule

`default_nettype wire

// File: rtl/csrTimer.sv
`timescale 1ns/1ns
`default_nettype none
`include "csr_settings.svh"

module csrTimer (
    input  wire logic                  clk,
    input  wire logic                  rstn,
    input  wire logic [31:0]           tcfg,
    input  wire logic                  tcfgWritten,
    input  wire logic                  grant,
    output csrPkg::csrWrite            req,
    output logic [`CSR_TIMER_BITS-1:0] tval
);

    logic [`CSR_TIMER_BITS-1:0] loadVal;
    logic                       stopped;
    logic                       pending;
    logic                       running;

    // tcfg bit 0 En, bit 1 Periodic, upper bits InitVal
    assign loadVal = {tcfg[`CSR_TIMER_BITS-1:2], 2'b00};
    assign running = tcfg[0] && !stopped && !tcfgWritten;

    assign req = '{we: pending, num: `CSR_ESTAT,
                   wdata: 32'b1 << `CSR_TI_BIT, wmask: 32'b1 << `CSR_TI_BIT};

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tval    <= '0;
            stopped <= 1'b0;
            pending <= 1'b0;
        end
        else
        begin
            if (tcfgWritten)
            begin
                tval    <= loadVal;
                stopped <= 1'b0;
            end
            else if (running)
            begin
                if (tval == '0)
                begin
                    if (tcfg[1])
                        tval <= loadVal;
                    else
                        stopped <= 1'b1;
                end
                else
                    tval <= tval - 1'b1;
            end
            // a new zero while waiting keeps the request up
            if (running && tval == '0)
                pending <= 1'b1;
            else if (grant)
                pending <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) req.we && !grant |=> req.we);

endmodule

`default_nettype wire

// File: rtl/csrUnit.sv
`timescale 1ns/1ns
`default_nettype none
`include "csr_settings.svh"

module csrUnit (
    input  wire logic         clk,
    input  wire logic         rstn,
    input  wire logic         valid,
    input  wire csrPkg::csrOp op,
    input  wire logic [13:0]  csrNum,
    input  wire logic [31:0]  wdata,
    input  wire logic [31:0]  wmask,
    input  wire logic [31:0]  pc,
    input  wire logic         stall,
    input  wire logic         flushIn,
    input  wire logic [7:0]   hwInt,
    output logic [31:0]       rdata,
    output logic              flush,
    output logic [31:0]       outPc,
    output logic              clkStall,
    output logic              busy
);

    csrPkg::csrWrite                  ctrlWr;
    csrPkg::csrWrite                  timerReq;
    csrPkg::csrWrite                  winner;
    csrPkg::csrWrite [`ARB_PORTS-1:0] reqs;
    csrPkg::csrTrap                   trap;
    csrPkg::csrStatus                 status;
    logic [`ARB_PORTS-1:0]            grants;
    logic                             timerGrant;
    logic [31:0]                      tcfg;
    logic                             tcfgWritten;
    logic [`CSR_TIMER_BITS-1:0]       tval;

    // port 0 is the instruction side
    assign reqs       = {timerReq, ctrlWr};
    assign timerGrant = grants[1];
    assign busy       = clkStall;

    csrControl control0 (
        .clk(clk), .rstn(rstn), .valid(valid), .op(op), .csrNum(csrNum),
        .wdata(wdata), .wmask(wmask), .pc(pc), .stall(stall), .flushIn(flushIn),
        .status(status), .wr(ctrlWr), .trap(trap), .flush(flush), .outPc(outPc),
        .clkStall(clkStall)
    );

    csrTimer timer0 (
        .clk(clk), .rstn(rstn), .tcfg(tcfg), .tcfgWritten(tcfgWritten),
        .grant(timerGrant), .req(timerReq), .tval(tval)
    );

    csrWriteArbiter arbiter0 (
        .reqs(reqs), .winner(winner), .grants(grants)
    );

    csrFile file0 (
        .clk(clk), .rstn(rstn), .wr(winner), .trap(trap), .rdNum(csrNum),
        .tval(tval), .hwInt(hwInt), .rdata(rdata), .status(status), .tcfg(tcfg),
        .ticlr(), .tcfgWritten(tcfgWritten)
    );

endmodule

`default_nettype wire

// File: test/csrModel.svh
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// reference copy of the CSR state, updated per accepted instruction
logic [8:0]  mCrmd;
logic [2:0]  mPrmd;
logic [12:0] mEcfg;
logic [1:0]  mSw;
logic [7:0]  mHw;
logic        mTi;
// timer line may set on its own while this is high
logic        mTiOpen;
logic [5:0]  mEcode;
logic [31:0] mEra;
logic [31:0] mEentry;
logic [31:0] mSave [4];
logic [31:0] mTid;
logic [15:0] mTcfg;

function automatic void modelReset();
    mCrmd   = 9'h8;
    mPrmd   = '0;
    mEcfg   = '0;
    mSw     = '0;
    mHw     = '0;
    mTi     = 1'b0;
    mTiOpen = 1'b0;
    mEcode  = '0;
    mEra    = '0;
    mEentry = '0;
    mSave   = '{default: '0};
    mTid    = '0;
    mTcfg   = '0;
endfunction

function automatic logic modelIntTaken();
    logic [12:0] enabled;
    enabled = {1'b0, mTi, 1'b0, mHw, mSw} & mEcfg;
    return mCrmd[2] && enabled != 13'b0;
endfunction

// bits that software may change in each register
function automatic logic [31:0] writableBits(input logic [13:0] num);
    case (num)
        `CSR_CRMD:   return 32'h1ff;
        `CSR_PRMD:   return 32'h7;
        `CSR_ECFG:   return 32'h1bff;
        `CSR_ESTAT:  return 32'h3;
        `CSR_EENTRY: return 32'hffff_ffc0;
        `CSR_TCFG:   return 32'hffff;
        `CSR_ERA, `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_TID:
            return 32'hffff_ffff;
        default:     return 32'h0;
    endcase
endfunction

function automatic logic [31:0] modelRead(input logic [13:0] num);
    case (num)
        `CSR_CRMD:   return {23'b0, mCrmd};
        `CSR_PRMD:   return {29'b0, mPrmd};
        `CSR_ECFG:   return {19'b0, mEcfg};
        // ecode sits in bits 21:16
        `CSR_ESTAT:  return {10'b0, mEcode, 3'b0, 1'b0, mTi, 1'b0, mHw, mSw};
        `CSR_ERA:    return mEra;
        `CSR_EENTRY: return mEentry;
        `CSR_SAVE0:  return mSave[0];
        `CSR_SAVE1:  return mSave[1];
        `CSR_SAVE2:  return mSave[2];
        `CSR_SAVE3:  return mSave[3];
        `CSR_TID:    return mTid;
        `CSR_TCFG:   return {16'b0, mTcfg};
        default:     return 32'h0;
    endcase
endfunction

function automatic void modelWrite(input logic [13:0] num, input logic [31:0] data,
                                   input logic [31:0] mask);
    logic [31:0] keep;
    logic [31:0] v;
    keep = mask & writableBits(num);
    v    = (modelRead(num) & ~keep) | (data & keep);
    case (num)
        `CSR_CRMD:   mCrmd = v[8:0];
        `CSR_PRMD:   mPrmd = v[2:0];
        `CSR_ECFG:   mEcfg = v[12:0];
        `CSR_ESTAT:  mSw = v[1:0];
        `CSR_ERA:    mEra = v;
        `CSR_EENTRY: mEentry = v;
        `CSR_SAVE0:  mSave[0] = v;
        `CSR_SAVE1:  mSave[1] = v;
        `CSR_SAVE2:  mSave[2] = v;
        `CSR_SAVE3:  mSave[3] = v;
        `CSR_TID:    mTid = v;
        `CSR_TCFG:   mTcfg = v[15:0];
        `CSR_TICLR:  if (data[0] && mask[0]) mTi = 1'b0;
        default:     ;
    endcase
endfunction

function automatic void modelTrap(input logic [5:0] ecode, input logic [31:0] era);
    mPrmd      = mCrmd[2:0];
    mCrmd[2:0] = 3'b0;
    mEra       = era;
    mEcode     = ecode;
endfunction

function automatic void modelErtn();
    mCrmd[2:0] = mPrmd;
endfunction

`endif

// File: test/csrUnitTb.sv
`timescale 1ns/1ns
`default_nettype none
`include "csr_settings.svh"

module csrUnitTb;

    localparam int RAND_OPS    = 300;
    localparam int TRAP_ROUNDS = 6;
    localparam int INT_ROUNDS  = 40;
    localparam int IDLE_ROUNDS = 4;
    localparam int WAKE_LIMIT  = 4;
    // all tests together need about 950 cycles
    localparam int TIMEOUT_CYCLES = 3000;

    logic         clk;
    logic         rstn;
    logic         valid;
    csrPkg::csrOp op;
    logic [13:0]  csrNum;
    logic [31:0]  wdata;
    logic [31:0]  wmask;
    logic [31:0]  pc;
    logic         stall;
    logic         flushIn;
    logic [7:0]   hwInt;
    logic [31:0]  rdata;
    logic         flush;
    logic [31:0]  outPc;
    logic         clkStall;
    logic         busy;

    logic [31:0]  gotRdata;
    int           errors;
    int           testStart;
    int           testsOk;
    int           testsBad;
    int           cycles = 0;
    logic [13:0]  regList [11];

    `include "csrModel.svh"

    csrUnit dut0 (.*);

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
        if (got !== expected)
        begin
            errors++;
            $display("mismatch at %0t: %s got 0x%08h expected 0x%08h",
                     $time, name, got, expected);
        end
    endtask

    task automatic problem(input string what);
        errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    task automatic finishTest(input string name);
        if (errors == testStart)
        begin
            testsOk++;
            $display("test %-8s ok", name);
        end
        else
        begin
            testsBad++;
            $display("test %-8s %0d errors", name, errors - testStart);
        end
        testStart = errors;
    endtask

    // one instruction, starting and ending 1 ns after a rising edge
    task automatic issue(input csrPkg::csrOp o, input logic [13:0] num,
                         input logic [31:0] data, input logic [31:0] mask,
                         input logic [31:0] addr);
        logic        taken;
        logic [31:0] care;
        taken  = modelIntTaken();
        care   = (num == `CSR_ESTAT && mTiOpen) ? ~(32'b1 << `CSR_TI_BIT) : '1;
        valid  = 1'b1;
        op     = o;
        csrNum = num;
        wdata  = data;
        wmask  = mask;
        pc     = addr;
        @(negedge clk);
        gotRdata = rdata;
        if (taken)
        begin
            compare("flush", 32'(flush), 32'd1);
            compare("outPc", outPc, mEentry);
            modelTrap(`ECODE_INT, addr);
        end
        else
        begin
            case (o)
                csrPkg::opRd, csrPkg::opWr, csrPkg::opXchg:
                begin
                    compare("rdata", rdata & care, modelRead(num) & care);
                    compare("flush", 32'(flush), 32'd0);
                    if (o == csrPkg::opWr)
                        modelWrite(num, data, '1);
                    else if (o == csrPkg::opXchg)
                        modelWrite(num, data, mask);
                end
                csrPkg::opSyscall, csrPkg::opBrk:
                begin
                    compare("flush", 32'(flush), 32'd1);
                    compare("outPc", outPc, mEentry);
                    modelTrap(o == csrPkg::opBrk ? `ECODE_BRK : `ECODE_SYS, addr);
                end
                csrPkg::opErtn:
                begin
                    compare("flush", 32'(flush), 32'd1);
                    compare("outPc", outPc, mEra);
                    modelErtn();
                end
                default: compare("flush", 32'(flush), 32'd0);
            endcase
        end
        @(posedge clk);
        #1;
        valid = 1'b0;
        op    = csrPkg::opNone;
    endtask

    task automatic readCsr(input logic [13:0] num);
        issue(csrPkg::opRd, num, 32'h0, 32'h0, $urandom);
    endtask

    task automatic writeCsr(input logic [13:0] num, input logic [31:0] data);
        issue(csrPkg::opWr, num, data, '1, $urandom);
    endtask

    // the first write either traps or clears IE, so IE is off afterwards
    task automatic maskInterrupts();
        writeCsr(`CSR_CRMD, 32'h8);
        writeCsr(`CSR_CRMD, 32'h8);
        writeCsr(`CSR_ECFG, 32'h0);
        writeCsr(`CSR_ESTAT, 32'h0);
    endtask

    // hardware lines are sampled one cycle late
    task automatic setHwInt(input logic [7:0] value);
        hwInt = value;
        @(posedge clk);
        #1;
        mHw = value;
    endtask

    initial
    begin
        logic [13:0] num;
        logic [31:0] data;
        int          line;
        int          count;
        int          waited;
        logic        seen;

        void'($urandom(42));
        clk       = 1'b0;
        rstn      = 1'b0;
        valid     = 1'b0;
        op        = csrPkg::opNone;
        csrNum    = '0;
        wdata     = '0;
        wmask     = '0;
        pc        = '0;
        stall     = 1'b0;
        flushIn   = 1'b0;
        hwInt     = '0;
        errors    = 0;
        testStart = 0;
        testsOk   = 0;
        testsBad  = 0;
        regList   = '{`CSR_CRMD, `CSR_PRMD, `CSR_ECFG, `CSR_ESTAT, `CSR_ERA, `CSR_EENTRY,
                      `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_TID};
        modelReset();
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;

        // IE stays off, so no interrupt is taken
        for (int i = 0; i < RAND_OPS; i++)
        begin
            num  = regList[$urandom % 11];
            data = $urandom;
            if (num == `CSR_CRMD)
                data[2] = 1'b0;
            case ($urandom % 3)
                0:       issue(csrPkg::opRd, num, data, $urandom, $urandom);
                1:       issue(csrPkg::opWr, num, data, $urandom, $urandom);
                default: issue(csrPkg::opXchg, num, data, $urandom, $urandom);
            endcase
        end
        finishTest("random");

        for (int i = 0; i < TRAP_ROUNDS; i++)
        begin
            writeCsr(`CSR_EENTRY, $urandom);
            writeCsr(`CSR_CRMD, $urandom & 32'hffff_fffb);
            issue((i % 2) ? csrPkg::opBrk : csrPkg::opSyscall, '0, '0, '0, $urandom);
            readCsr(`CSR_PRMD);
            readCsr(`CSR_CRMD);
            readCsr(`CSR_ERA);
            readCsr(`CSR_ESTAT);
            issue(csrPkg::opErtn, '0, '0, '0, $urandom);
            readCsr(`CSR_CRMD);
        end
        finishTest("trap");

        for (int i = 0; i < INT_ROUNDS; i++)
        begin
            maskInterrupts();
            setHwInt($urandom & $urandom);
            writeCsr(`CSR_ECFG, $urandom & $urandom);
            writeCsr(`CSR_ESTAT, $urandom);
            writeCsr(`CSR_CRMD, $urandom);
            // traps exactly when the model sees an enabled line with IE on
            readCsr(`CSR_SAVE0);
            readCsr(`CSR_ESTAT);
        end
        setHwInt(8'h0);
        finishTest("interrupt");

        for (int i = 0; i < IDLE_ROUNDS; i++)
        begin
            maskInterrupts();
            line = $urandom % 8;
            writeCsr(`CSR_ECFG, 32'b1 << (line + 2));
            issue(csrPkg::opIdle, '0, '0, '0, $urandom);
            compare("clkStall", 32'(clkStall), 32'd1);
            compare("busy", 32'(busy), 32'd1);
            // a line that is not enabled keeps the core asleep
            setHwInt(8'b1 << ((line + 1) % 8));
            repeat (2 + $urandom % 4)
            begin
                @(posedge clk);
                #1;
                compare("clkStall", 32'(clkStall), 32'd1);
            end
            setHwInt(hwInt | (8'b1 << line));
            waited = 0;
            while (clkStall && waited < WAKE_LIMIT)
            begin
                @(posedge clk);
                #1;
                waited++;
            end
            if (clkStall)
                problem("clock stall did not end after an enabled interrupt line rose");
            compare("busy", 32'(busy), 32'd0);
            setHwInt(8'h0);
        end
        finishTest("idle");

        maskInterrupts();
        // InitVal field 3..6, counted in steps of four
        count = 4 * (3 + $urandom % 4);
        writeCsr(`CSR_TCFG, 32'(count) | 32'h1);
        mTiOpen = 1'b1;
        for (int i = 0; i < count; i++)
            writeCsr(`CSR_SAVE1, $urandom);
        seen = 1'b0;
        for (int i = 0; i < 4 && !seen; i++)
        begin
            readCsr(`CSR_ESTAT);
            seen = gotRdata[`CSR_TI_BIT];
        end
        if (!seen)
            problem("timer interrupt bit not set within InitVal plus 4 cycles");
        else
            mTi = 1'b1;
        mTiOpen = 1'b0;
        readCsr(`CSR_ESTAT);
        writeCsr(`CSR_TICLR, 32'h1);
        // one-shot, so the bit must stay clear
        for (int i = 0; i < 3 * count; i++)
            readCsr(`CSR_ESTAT);
        finishTest("timer");

        $display("tests: %0d ok, %0d with errors, %0d errors in total",
                 testsOk, testsBad, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+rtl
+incdir+test
rtl/csrPkg.sv
rtl/csrWriteArbiter.sv
rtl/csrFile.sv
rtl/csrControl.sv
rtl/csrTimer.sv
rtl/csrUnit.sv
test/csrUnitTb.sv

// File: run.sh
#!/bin/sh
# builds the csrUnit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    -f sources.f --top-module csrUnitTb -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build returned status $status"
    exit 1
fi

out=$(./obj_dir/simv)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
